// ==== Bender.yml ====
package:
  name: function_plotter

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/plot_pkg.sv
      - common/token_vector_if.sv
      - plot/token_vector.sv
      - plot/expr_parser.sv
      - plot/rpn_evaluator.sv
      - plot/plot_sequencer.sv
      - src/function_plotter.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_function_plotter.sv

// ==== common/plot_config.svh ====
`ifndef PLOT_CONFIG_SVH
`define PLOT_CONFIG_SVH

// display geometry
`define PLOT_HOR_PIXELS 640
`define PLOT_VER_PIXELS 480

`define PLOT_SYMBOL_WIDTH 7

// signed 11.8 fixed point
`define PLOT_INT_WIDTH  11
`define PLOT_FRAC_WIDTH 8
`define PLOT_NUM_WIDTH  (`PLOT_INT_WIDTH + `PLOT_FRAC_WIDTH)

// token vector and stacks
`define PLOT_QUEUE_DEPTH      64
`define PLOT_INDEX_WIDTH      $clog2(`PLOT_QUEUE_DEPTH)
`define PLOT_LENGTH_WIDTH     (`PLOT_INDEX_WIDTH + 1)
`define PLOT_STACK_DEPTH      16
`define PLOT_STACK_PTR_WIDTH  ($clog2(`PLOT_STACK_DEPTH) + 1)

`endif

// ==== common/plot_pkg.sv ====
`include "plot_config.svh"

package plot_pkg;

   // 11.8 two's complement
   typedef logic signed [`PLOT_NUM_WIDTH-1:0] fixed_t;

   typedef enum logic [2:0] {
      OP_ADD,
      OP_SUB,
      OP_MUL,
      OP_VAR,
      OP_LPAREN
   } op_code_e;

   typedef struct packed {
      logic [`PLOT_NUM_WIDTH-4:0] pad;
      op_code_e                   code;
   } op_view_t;

   // same word, number or operator
   typedef union packed {
      fixed_t   num;
      op_view_t op;
   } token_payload_u;

   typedef struct packed {
      logic           is_op;
      token_payload_u payload;
   } token_t;

   typedef logic [$clog2(`PLOT_HOR_PIXELS)-1:0] x_coord_t;
   typedef logic [$clog2(`PLOT_VER_PIXELS)-1:0] y_coord_t;

endpackage

// ==== common/token_vector_if.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

interface token_vector_if;

   logic [`PLOT_INDEX_WIDTH-1:0]  wr_index;
   logic [`PLOT_INDEX_WIDTH-1:0]  rd_index;
   logic                          insert;
   logic                          get;
   plot_pkg::token_t              data_in;
   plot_pkg::token_t              data_out;
   logic [`PLOT_LENGTH_WIDTH-1:0] length;
   logic                          ready;

   // parser side
   modport writer (
      output wr_index, insert, data_in,
      input  ready
   );

   // evaluator side
   modport reader (
      output rd_index, get,
      input  data_out, length, ready
   );

   modport storage (
      input  wr_index, rd_index, insert, get, data_in,
      output data_out, length, ready
   );

endinterface

// ==== plot/expr_parser.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module expr_parser (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   output logic                          ready,
   token_vector_if.writer                vec,
   input  logic [`PLOT_SYMBOL_WIDTH-1:0] symbol,
   input  logic                          symbol_valid,
   output logic                          symbol_iter_en
);

   typedef enum logic [1:0] {S_IDLE, S_READ, S_ADV} state_e;

   state_e                             state;
   plot_pkg::op_code_e                 op_stack [`PLOT_STACK_DEPTH];
   logic [`PLOT_STACK_PTR_WIDTH-1:0]   sp;
   logic [`PLOT_STACK_PTR_WIDTH-2:0]   top_idx;
   logic [`PLOT_INDEX_WIDTH-1:0]       wr_ptr;
   logic [`PLOT_INT_WIDTH-1:0]         int_acc;
   logic                               num_pending;
   plot_pkg::op_code_e                 top_op;
   plot_pkg::op_code_e                 sym_op;
   plot_pkg::op_code_e                 push_op;
   plot_pkg::token_t                   emit_tok;
   logic                               stack_empty;
   logic                               is_digit;
   logic                               do_emit;
   logic                               do_push;
   logic                               do_pop;
   logic                               do_consume;
   logic                               do_done;

   function automatic plot_pkg::token_t op_token(plot_pkg::op_code_e code);
      plot_pkg::token_t t;
      t.is_op           = 1'b1;
      t.payload.op.pad  = '0;
      t.payload.op.code = code;
      return t;
   endfunction

   function automatic logic prec_high(plot_pkg::op_code_e code);
      return code == plot_pkg::OP_MUL;
   endfunction

   assign top_idx        = sp[`PLOT_STACK_PTR_WIDTH-2:0] - 1'b1;
   assign top_op         = op_stack[top_idx];
   assign stack_empty    = (sp == '0);
   assign is_digit       = (symbol >= "0") && (symbol <= "9");
   assign vec.wr_index   = wr_ptr;

   always_comb begin
      do_emit            = 1'b0;
      do_push            = 1'b0;
      do_pop             = 1'b0;
      do_consume         = 1'b0;
      do_done            = 1'b0;
      push_op            = plot_pkg::OP_LPAREN;
      emit_tok.is_op     = 1'b0;
      emit_tok.payload.num = plot_pkg::fixed_t'({int_acc, {`PLOT_FRAC_WIDTH{1'b0}}});
      sym_op = (symbol == "+") ? plot_pkg::OP_ADD :
               (symbol == "-") ? plot_pkg::OP_SUB : plot_pkg::OP_MUL;

      if (state == S_READ && symbol_valid && vec.ready) begin
         if (is_digit) begin
            do_consume = 1'b1;
         end else if (num_pending) begin
            // literal ends here, symbol stays for the next cycle
            do_emit = 1'b1;
         end else begin
            case (symbol)
               "x": begin
                  do_emit    = 1'b1;
                  emit_tok   = op_token(plot_pkg::OP_VAR);
                  do_consume = 1'b1;
               end
               "(": begin
                  do_push    = 1'b1;
                  do_consume = 1'b1;
               end
               ")": begin
                  if (!stack_empty && top_op != plot_pkg::OP_LPAREN) begin
                     do_pop   = 1'b1;
                     do_emit  = 1'b1;
                     emit_tok = op_token(top_op);
                  end else begin
                     do_pop     = !stack_empty;
                     do_consume = 1'b1;
                  end
               end
               "+", "-", "*": begin
                  if (!stack_empty && top_op != plot_pkg::OP_LPAREN &&
                      prec_high(top_op) >= prec_high(sym_op)) begin
                     do_pop   = 1'b1;
                     do_emit  = 1'b1;
                     emit_tok = op_token(top_op);
                  end else begin
                     do_push    = 1'b1;
                     push_op    = sym_op;
                     do_consume = 1'b1;
                  end
               end
               ";": begin
                  if (!stack_empty) begin
                     do_pop   = 1'b1;
                     do_emit  = (top_op != plot_pkg::OP_LPAREN);
                     emit_tok = op_token(top_op);
                  end else begin
                     do_consume = 1'b1;
                     do_done    = 1'b1;
                  end
               end
               default: do_consume = 1'b1;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         op_stack[sp[`PLOT_STACK_PTR_WIDTH-2:0]] <= push_op;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= S_IDLE;
         ready          <= 1'b1;
         sp             <= '0;
         wr_ptr         <= '0;
         int_acc        <= '0;
         num_pending    <= 1'b0;
         vec.insert     <= 1'b0;
         vec.data_in    <= '0;
         symbol_iter_en <= 1'b0;
      end else begin
         vec.insert     <= do_emit;
         symbol_iter_en <= do_consume;
         if (do_emit) begin
            vec.data_in <= emit_tok;
         end
         // write index moves once the insert has gone out
         if (vec.insert) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_push) begin
            sp <= sp + 1'b1;
         end else if (do_pop) begin
            sp <= sp - 1'b1;
         end
         if (do_consume && is_digit) begin
            int_acc     <= int_acc * 4'd10 + symbol[3:0];
            num_pending <= 1'b1;
         end else if (do_emit && num_pending) begin
            int_acc     <= '0;
            num_pending <= 1'b0;
         end

         case (state)
            S_IDLE: begin
               if (start && ready) begin
                  ready  <= 1'b0;
                  sp     <= '0;
                  wr_ptr <= '0;
                  state  <= S_READ;
               end
            end
            S_READ: begin
               if (do_done) begin
                  ready <= 1'b1;
                  state <= S_IDLE;
               end else if (do_consume) begin
                  state <= S_ADV;
               end
            end
            // source advances on this cycle's strobe
            default: state <= S_READ;
         endcase
      end
   end

endmodule

// ==== plot/plot_sequencer.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module plot_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   output logic               ready,
   output logic               parse_start,
   input  logic               parse_ready,
   output logic               eval_start,
   input  logic               eval_ready,
   output plot_pkg::x_coord_t eval_x,
   input  plot_pkg::y_coord_t eval_y,
   output logic               read_sel,
   output plot_pkg::x_coord_t x1,
   output plot_pkg::y_coord_t y1,
   output plot_pkg::x_coord_t x2,
   output plot_pkg::y_coord_t y2,
   output logic               line_start,
   input  logic               line_ready
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_PARSE_ACK,
      S_PARSE_WAIT,
      S_CALC,
      S_CALC_ACK,
      S_CALC_WAIT,
      S_DRAW,
      S_LINE_ACK,
      S_LINE_WAIT
   } state_e;

   state_e state;
   logic   first_col;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         ready       <= 1'b1;
         parse_start <= 1'b0;
         eval_start  <= 1'b0;
         line_start  <= 1'b0;
         read_sel    <= 1'b0;
         first_col   <= 1'b1;
         eval_x      <= '0;
         x1          <= '0;
         y1          <= '0;
         x2          <= '0;
         y2          <= '0;
      end else begin
         parse_start <= 1'b0;
         eval_start  <= 1'b0;
         line_start  <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start && ready) begin
                  ready       <= 1'b0;
                  read_sel    <= 1'b0;
                  parse_start <= 1'b1;
                  state       <= S_PARSE_ACK;
               end
            end
            // busy flags drop one cycle after a start pulse
            S_PARSE_ACK: state <= S_PARSE_WAIT;
            S_PARSE_WAIT: begin
               if (parse_ready) begin
                  read_sel  <= 1'b1;
                  eval_x    <= '0;
                  first_col <= 1'b1;
                  state     <= S_CALC;
               end
            end
            S_CALC: begin
               if (eval_x == `PLOT_HOR_PIXELS) begin
                  ready <= 1'b1;
                  state <= S_IDLE;
               end else begin
                  eval_start <= 1'b1;
                  state      <= S_CALC_ACK;
               end
            end
            S_CALC_ACK: state <= S_CALC_WAIT;
            S_CALC_WAIT: begin
               if (eval_ready) begin
                  state <= S_DRAW;
               end
            end
            S_DRAW: begin
               if (first_col) begin
                  // first point only seeds the segment
                  x2        <= eval_x;
                  y2        <= eval_y;
                  first_col <= 1'b0;
                  eval_x    <= eval_x + 1'b1;
                  state     <= S_CALC;
               end else if (line_ready) begin
                  x1         <= x2;
                  y1         <= y2;
                  x2         <= eval_x;
                  y2         <= eval_y;
                  line_start <= 1'b1;
                  state      <= S_LINE_ACK;
               end
            end
            S_LINE_ACK: state <= S_LINE_WAIT;
            default: begin
               if (line_ready) begin
                  eval_x <= eval_x + 1'b1;
                  state  <= S_CALC;
               end
            end
         endcase
      end
   end

endmodule

// ==== plot/rpn_evaluator.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module rpn_evaluator (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   output logic               ready,
   input  plot_pkg::x_coord_t x_in,
   output plot_pkg::y_coord_t y_out,
   token_vector_if.reader     vec
);

   typedef enum logic [2:0] {S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_CLAMP} state_e;

   state_e                                 state;
   plot_pkg::fixed_t                       val_stack [`PLOT_STACK_DEPTH];
   logic [`PLOT_STACK_PTR_WIDTH-1:0]       sp;
   logic [`PLOT_STACK_PTR_WIDTH-2:0]       top_idx;
   logic [`PLOT_STACK_PTR_WIDTH-2:0]       nxt_idx;
   logic [`PLOT_STACK_PTR_WIDTH-2:0]       wr_slot;
   logic [`PLOT_LENGTH_WIDTH-1:0]          pos;
   plot_pkg::token_t                       tok;
   plot_pkg::fixed_t                       opnd_a;
   plot_pkg::fixed_t                       opnd_b;
   plot_pkg::fixed_t                       alu_res;
   plot_pkg::fixed_t                       wr_val;
   logic signed [2*`PLOT_NUM_WIDTH-1:0]    product;
   logic                                   is_binary;
   logic signed [`PLOT_INT_WIDTH-1:0]      int_part;

   assign top_idx      = sp[`PLOT_STACK_PTR_WIDTH-2:0] - 1'b1;
   assign nxt_idx      = sp[`PLOT_STACK_PTR_WIDTH-2:0] - 2'd2;
   assign vec.rd_index = pos[`PLOT_INDEX_WIDTH-1:0];
   assign int_part     = val_stack[top_idx][`PLOT_NUM_WIDTH-1:`PLOT_FRAC_WIDTH];

   always_comb begin
      tok       = vec.data_out;
      opnd_a    = val_stack[nxt_idx];
      opnd_b    = val_stack[top_idx];
      product   = opnd_a * opnd_b;
      is_binary = tok.is_op && (tok.payload.op.code != plot_pkg::OP_VAR);

      case (tok.payload.op.code)
         plot_pkg::OP_ADD: alu_res = opnd_a + opnd_b;
         plot_pkg::OP_SUB: alu_res = opnd_a - opnd_b;
         // full product back to 11.8, upper bits dropped
         default:          alu_res = plot_pkg::fixed_t'(product >>> `PLOT_FRAC_WIDTH);
      endcase

      if (!tok.is_op) begin
         wr_val = tok.payload.num;
      end else if (!is_binary) begin
         wr_val = plot_pkg::fixed_t'({x_in, {`PLOT_FRAC_WIDTH{1'b0}}});
      end else begin
         wr_val = alu_res;
      end
      wr_slot = is_binary ? nxt_idx : sp[`PLOT_STACK_PTR_WIDTH-2:0];
   end

   always_ff @(posedge clk) begin
      if (state == S_EXEC) begin
         val_stack[wr_slot] <= wr_val;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         ready   <= 1'b1;
         vec.get <= 1'b0;
         pos     <= '0;
         sp      <= '0;
         y_out   <= '0;
      end else begin
         vec.get <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start && ready) begin
                  ready <= 1'b0;
                  pos   <= '0;
                  sp    <= '0;
                  state <= S_FETCH;
               end
            end
            S_FETCH: begin
               if (pos == vec.length) begin
                  state <= S_CLAMP;
               end else if (vec.ready) begin
                  vec.get <= 1'b1;
                  state   <= S_WAIT;
               end
            end
            S_WAIT: state <= S_EXEC;
            S_EXEC: begin
               sp    <= is_binary ? sp - 1'b1 : sp + 1'b1;
               pos   <= pos + 1'b1;
               state <= S_FETCH;
            end
            default: begin
               // clamp to a visible row
               if (int_part < 0) begin
                  y_out <= '0;
               end else if (int_part > `PLOT_VER_PIXELS - 1) begin
                  y_out <= plot_pkg::y_coord_t'(`PLOT_VER_PIXELS - 1);
               end else begin
                  y_out <= int_part[$bits(plot_pkg::y_coord_t)-1:0];
               end
               ready <= 1'b1;
               state <= S_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== plot/token_vector.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module token_vector (
   input logic           clk,
   input logic           rst_n,
   token_vector_if.storage mem,
   input logic           read_sel
);

   plot_pkg::token_t            store [`PLOT_QUEUE_DEPTH];
   logic [`PLOT_INDEX_WIDTH-1:0] index;

   // evaluator owns the index once parsing is over
   assign index = read_sel ? mem.rd_index : mem.wr_index;

   always_ff @(posedge clk) begin
      if (mem.insert) begin
         store[index] <= mem.data_in;
      end
      if (mem.get) begin
         mem.data_out <= store[index];
      end
   end

   // length follows the last insert, so index 0 restarts the program
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem.length <= '0;
         mem.ready  <= 1'b1;
      end else begin
         mem.ready <= 1'b1;
         if (mem.insert) begin
            mem.length <= {1'b0, index} + 1'b1;
         end
      end
   end

endmodule

// ==== src/function_plotter.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module function_plotter (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   output logic                          ready,
   input  logic [`PLOT_SYMBOL_WIDTH-1:0] symbol,
   input  logic                          symbol_valid,
   output logic                          symbol_iter_en,
   output plot_pkg::x_coord_t            x1,
   output plot_pkg::y_coord_t            y1,
   output plot_pkg::x_coord_t            x2,
   output plot_pkg::y_coord_t            y2,
   output logic                          line_start,
   input  logic                          line_ready
);

   logic               parse_start;
   logic               parse_ready;
   logic               eval_start;
   logic               eval_ready;
   logic               read_sel;
   plot_pkg::x_coord_t eval_x;
   plot_pkg::y_coord_t eval_y;

   token_vector_if tokens ();

   token_vector vector (
      .clk      (clk),
      .rst_n    (rst_n),
      .mem      (tokens.storage),
      .read_sel (read_sel)
   );

   expr_parser parser (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (parse_start),
      .ready          (parse_ready),
      .vec            (tokens.writer),
      .symbol         (symbol),
      .symbol_valid   (symbol_valid),
      .symbol_iter_en (symbol_iter_en)
   );

   rpn_evaluator evaluator (
      .clk   (clk),
      .rst_n (rst_n),
      .start (eval_start),
      .ready (eval_ready),
      .x_in  (eval_x),
      .y_out (eval_y),
      .vec   (tokens.reader)
   );

   plot_sequencer sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .ready       (ready),
      .parse_start (parse_start),
      .parse_ready (parse_ready),
      .eval_start  (eval_start),
      .eval_ready  (eval_ready),
      .eval_x      (eval_x),
      .eval_y      (eval_y),
      .read_sel    (read_sel),
      .x1          (x1),
      .y1          (y1),
      .x2          (x2),
      .y2          (y2),
      .line_start  (line_start),
      .line_ready  (line_ready)
   );

endmodule

// ==== test/tb_plot_model.svh ====
`ifndef TB_PLOT_MODEL_SVH
`define TB_PLOT_MODEL_SVH

// reference RPN program, one entry per token
int     rpn_count;
bit     rpn_is_op [`PLOT_QUEUE_DEPTH];
longint rpn_value [`PLOT_QUEUE_DEPTH];
byte    rpn_op [`PLOT_QUEUE_DEPTH];

localparam longint num_range = longint'(1) << (`PLOT_INT_WIDTH + `PLOT_FRAC_WIDTH);

// two's complement wrap into the 11.8 word
function automatic longint wrap_fixed(input longint v);
   longint m;
   m = v % num_range;
   if (m < 0) begin
      m = m + num_range;
   end
   if (m >= num_range / 2) begin
      m = m - num_range;
   end
   return m;
endfunction

function automatic int op_rank(input byte op);
   return (op == "*") ? 1 : 0;
endfunction

function automatic void push_token(input bit is_op, input longint value, input byte op);
   rpn_is_op[rpn_count] = is_op;
   rpn_value[rpn_count] = value;
   rpn_op[rpn_count]    = op;
   rpn_count++;
endfunction

// shunting-yard over the expression text
function automatic void parse_to_rpn(input string expr);
   byte    ops [`PLOT_STACK_DEPTH];
   int     sp;
   int     i;
   longint acc;
   bit     pending;
   bit     done;
   byte    c;
   sp        = 0;
   acc       = 0;
   pending   = 1'b0;
   done      = 1'b0;
   rpn_count = 0;
   for (i = 0; i < expr.len() && !done; i++) begin
      c = expr[i];
      if (c >= "0" && c <= "9") begin
         acc     = acc * 10 + (c - "0");
         pending = 1'b1;
      end else begin
         if (pending) begin
            push_token(1'b0, wrap_fixed(acc << `PLOT_FRAC_WIDTH), 0);
            acc     = 0;
            pending = 1'b0;
         end
         case (c)
            "x": push_token(1'b1, 0, "x");
            "(": begin
               ops[sp] = c;
               sp++;
            end
            ")": begin
               while (sp > 0 && ops[sp-1] != "(") begin
                  push_token(1'b1, 0, ops[sp-1]);
                  sp--;
               end
               if (sp > 0) begin
                  sp--;
               end
            end
            "+", "-", "*": begin
               // equal rank pops first, so + and - group left
               while (sp > 0 && ops[sp-1] != "(" && op_rank(ops[sp-1]) >= op_rank(c)) begin
                  push_token(1'b1, 0, ops[sp-1]);
                  sp--;
               end
               ops[sp] = c;
               sp++;
            end
            ";": begin
               while (sp > 0) begin
                  if (ops[sp-1] != "(") begin
                     push_token(1'b1, 0, ops[sp-1]);
                  end
                  sp--;
               end
               done = 1'b1;
            end
            default: ;
         endcase
      end
   end
endfunction

// row of one column, clamped to the screen
function automatic int row_at(input int x);
   longint stack [`PLOT_STACK_DEPTH];
   int     sp;
   int     i;
   longint a;
   longint b;
   longint ip;
   int     row;
   sp = 0;
   for (i = 0; i < rpn_count; i++) begin
      if (!rpn_is_op[i]) begin
         stack[sp] = rpn_value[i];
         sp++;
      end else if (rpn_op[i] == "x") begin
         stack[sp] = longint'(x) << `PLOT_FRAC_WIDTH;
         sp++;
      end else begin
         b  = stack[sp-1];
         a  = stack[sp-2];
         sp = sp - 1;
         case (rpn_op[i])
            "+": stack[sp-1] = wrap_fixed(a + b);
            "-": stack[sp-1] = wrap_fixed(a - b);
            default: stack[sp-1] = wrap_fixed((a * b) >>> `PLOT_FRAC_WIDTH);
         endcase
      end
   end
   ip = stack[sp-1] >>> `PLOT_FRAC_WIDTH;
   if (ip < 0) begin
      row = 0;
   end else if (ip > `PLOT_VER_PIXELS - 1) begin
      row = `PLOT_VER_PIXELS - 1;
   end else begin
      row = int'(ip);
   end
   return row;
endfunction

function automatic bit [31:0] lcg_step(input bit [31:0] state);
   return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== test/tb_function_plotter.sv ====
`timescale 1ns/10ps
`include "plot_config.svh"

module tb_function_plotter;

   localparam bit [31:0] random_seed   = 32'he91f52e7;
   localparam int        clk_period    = 10;
   localparam int        job_count     = 6;
   // generous bound for evaluation plus drawer stalls
   localparam int        column_cycles = 200;
   localparam longint    watchdog_ns   =
      longint'(job_count) * `PLOT_HOR_PIXELS * column_cycles * clk_period + 1000;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          start;
   logic                          ready;
   logic [`PLOT_SYMBOL_WIDTH-1:0] symbol;
   logic                          symbol_valid;
   logic                          symbol_iter_en;
   plot_pkg::x_coord_t            x1;
   plot_pkg::y_coord_t            y1;
   plot_pkg::x_coord_t            x2;
   plot_pkg::y_coord_t            y2;
   logic                          line_start;
   logic                          line_ready;

   string     src_text;
   int        src_pos;
   bit        gap_mode;
   bit        delay_mode;
   bit [31:0] gap_state;
   bit [31:0] delay_state;
   int        busy_cycles;
   int        exp_row [`PLOT_HOR_PIXELS];
   int        seg_count;
   int        error_count;
   int        test_count;
   int        failed_tests;

   `include "tb_plot_model.svh"

   function_plotter dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (start),
      .ready          (ready),
      .symbol         (symbol),
      .symbol_valid   (symbol_valid),
      .symbol_iter_en (symbol_iter_en),
      .x1             (x1),
      .y1             (y1),
      .x2             (x2),
      .y2             (y2),
      .line_start     (line_start),
      .line_ready     (line_ready)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic report_mismatch(input string name, input int expected, input int actual);
      $display("Mismatch at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
      error_count++;
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0d ns: %s", $time, what);
      error_count++;
   endtask

   // symbol source, steps to the next character on each consume strobe
   always begin : symbol_source
      byte ch;
      @(posedge clk);
      #1;
      if (symbol_iter_en) begin
         src_pos++;
      end
      if (src_pos < src_text.len()) begin
         ch           = src_text[src_pos];
         symbol       = ch[`PLOT_SYMBOL_WIDTH-1:0];
         symbol_valid = 1'b1;
         if (gap_mode) begin
            gap_state    = lcg_step(gap_state);
            symbol_valid = (gap_state[31:30] != 2'b00);
         end
      end else begin
         symbol       = '0;
         symbol_valid = 1'b0;
      end
   end

   // line drawer model, busy for a while after each segment
   always begin : line_drawer
      @(posedge clk);
      #1;
      if (busy_cycles > 0) begin
         busy_cycles--;
      end
      if (line_start) begin
         busy_cycles = 0;
         if (delay_mode) begin
            delay_state = lcg_step(delay_state);
            busy_cycles = delay_state[31:28];
         end
      end
      line_ready = (busy_cycles == 0);
   end

   always begin : segment_compare
      @(posedge clk);
      #1;
      if (line_start) begin
         if (seg_count >= `PLOT_HOR_PIXELS - 1) begin
            report_failure("line_start pulse beyond the last column");
         end else begin
            if (x1 !== seg_count) begin
               report_mismatch("x1", seg_count, x1);
            end
            if (x2 !== seg_count + 1) begin
               report_mismatch("x2", seg_count + 1, x2);
            end
            if (y1 !== exp_row[seg_count]) begin
               report_mismatch("y1", exp_row[seg_count], y1);
            end
            if (y2 !== exp_row[seg_count + 1]) begin
               report_mismatch("y2", exp_row[seg_count + 1], y2);
            end
         end
         seg_count++;
      end
   end

   task automatic run_job(input string expr, input bit gaps, input bit delays);
      int x;
      parse_to_rpn(expr);
      for (x = 0; x < `PLOT_HOR_PIXELS; x++) begin
         exp_row[x] = row_at(x);
      end
      gap_mode   = gaps;
      delay_mode = delays;
      src_text   = expr;
      src_pos    = 0;
      seg_count  = 0;
      if (ready !== 1'b1) begin
         report_failure("ready is low before the start pulse");
      end
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      while (ready !== 1'b1) begin
         @(posedge clk);
         #1;
      end
      if (seg_count != `PLOT_HOR_PIXELS - 1) begin
         $display("Error at %0d ns: job gave %0d segments instead of %0d",
                  $time, seg_count, `PLOT_HOR_PIXELS - 1);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: FAILED with %0d errors", test_count, name,
                  error_count - errors_before);
      end
   endtask

   initial begin : main_sequence
      int mark;
      rst_n        = 1'b0;
      start        = 1'b0;
      symbol       = '0;
      symbol_valid = 1'b0;
      line_ready   = 1'b1;
      gap_state    = random_seed;
      delay_state  = ~random_seed;
      src_text     = "";
      src_pos      = 0;
      gap_mode     = 1'b0;
      delay_mode   = 1'b0;
      busy_cycles  = 0;
      seg_count    = 0;
      error_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      mark = error_count;
      if (ready !== 1'b1) begin
         report_mismatch("ready", 1, ready);
      end
      if (line_start !== 1'b0) begin
         report_mismatch("line_start", 0, line_start);
      end
      if (symbol_iter_en !== 1'b0) begin
         report_mismatch("symbol_iter_en", 0, symbol_iter_en);
      end
      finish_test("reset state", mark);

      mark = error_count;
      run_job("7;", 1'b0, 1'b0);
      finish_test("constant", mark);

      mark = error_count;
      run_job("x+100-3*2;", 1'b0, 1'b0);
      finish_test("precedence and top clamp", mark);

      mark = error_count;
      run_job("(x-20)*(x-20)-(x*2);", 1'b0, 1'b0);
      finish_test("parentheses and multiply wrap", mark);

      mark = error_count;
      run_job("  (x*3 + 45) - 2*(x - 100) ;", 1'b1, 1'b1);
      finish_test("symbol gaps and drawer stalls", mark);

      // long program first, then a short one over it
      mark = error_count;
      run_job("((x+1)*(x+2)-x*x)*2+17-5;", 1'b0, 1'b0);
      run_job("x;", 1'b0, 1'b1);
      finish_test("token vector rebuilt", mark);

      $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("Timeout: the jobs did not finish within %0d ns", watchdog_ns);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+test
common/plot_pkg.sv
common/token_vector_if.sv
plot/token_vector.sv
plot/expr_parser.sv
plot/rpn_evaluator.sv
plot/plot_sequencer.sv
src/function_plotter.sv
test/tb_function_plotter.sv
